// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // Instruction field widths
  localparam int OP_WIDTH  = 3;
  localparam int IMM_WIDTH = 16;

  typedef logic [OP_WIDTH-1:0]  opcode_t;
  typedef logic [IMM_WIDTH-1:0] imm_t;

  // Opcodes, a is source 1 and b is source 2
  // ADD and SUB wrap modulo 2^32
  localparam opcode_t OP_ADD = 3'd0;
  localparam opcode_t OP_SUB = 3'd1;
  localparam opcode_t OP_AND = 3'd2;
  localparam opcode_t OP_OR  = 3'd3;
  localparam opcode_t OP_XOR = 3'd4;
  // Logical shifts of a, amount is the low five bits of b
  localparam opcode_t OP_SHL = 3'd5;
  localparam opcode_t OP_SHR = 3'd6;
  // Load immediate, zero extended, both sources ignored
  localparam opcode_t OP_LDI = 3'd7;

endpackage

`default_nettype wire

// ==== common/operand_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Carries one fetched instruction and its operand values
// from the fetch stage into the execute stage
interface operand_bus_if;

  // One-cycle strobe per instruction, no handshake
  logic valid;

  // Decoded instruction fields, delayed to match the read data
  isa_pkg::opcode_t op;
  reg_pkg::reg_idx_t dst;
  reg_pkg::reg_idx_t src1;
  reg_pkg::reg_idx_t src2;
  isa_pkg::imm_t imm;

  // Register file read data for src1 and src2
  reg_pkg::reg_word_t a;
  reg_pkg::reg_word_t b;

  // Fetch side drives everything
  modport fetch (output valid, op, dst, src1, src2, imm, a, b);

  // Execute side only listens
  modport exec (input valid, op, dst, src1, src2, imm, a, b);

endinterface

`default_nettype wire

// ==== common/reg_pkg.sv ====
`default_nettype none

package reg_pkg;

  // Register file geometry
  // One architectural register per SRAM word
  localparam int NUM_REGS = 32;

  // Width of every register value and ALU result
  localparam int REG_WIDTH = 32;

  // Enough bits to name any of the NUM_REGS registers
  localparam int REG_IDX_WIDTH = 5;

  // A value held in a register or produced by the ALU
  typedef logic [REG_WIDTH-1:0] reg_word_t;

  // A register number, used for sources and destination
  typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== compile.f ====
common/reg_pkg.sv
common/isa_pkg.sv
common/operand_bus_if.sv
source/sram_2r1w.sv
source/operand_fetch.sv
source/execute_stage.sv
source/reg_exec_top.sv
tests/reg_exec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module reg_exec_tb

# The simulator exits non-zero on a failed check; the search below decides
sim_out=$(./obj_dir/Vreg_exec_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "Test completed successfully"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// Execute stage
// Forwarding, ALU and the writeback register
module execute_stage (
  input  logic                clk,
  input  logic                rst,
  operand_bus_if.exec         bus,
  output logic                wb_en,
  output reg_pkg::reg_idx_t   wb_dst,
  output reg_pkg::reg_word_t  wb_data
);

  // Operands after the forward mux
  reg_pkg::reg_word_t op_a;
  reg_pkg::reg_word_t op_b;

  // Forward select per source
  logic fwd_a;
  logic fwd_b;

  // Combinational ALU output
  reg_pkg::reg_word_t alu_result;

  // Distance 1 hazard
  // The previous instruction sits in the writeback register and has
  // not reached the register file yet, so its value replaces the
  // stale SRAM read
  // Distance 2 is already handled inside the SRAM
  assign fwd_a = wb_en && (wb_dst == bus.src1);
  assign fwd_b = wb_en && (wb_dst == bus.src2);

  assign op_a = fwd_a ? wb_data : bus.a;
  assign op_b = fwd_b ? wb_data : bus.b;

  always_comb
  begin
    alu_result = '0;
    case (bus.op)
      isa_pkg::OP_ADD:
        alu_result = op_a + op_b;
      isa_pkg::OP_SUB:
        alu_result = op_a - op_b;
      isa_pkg::OP_AND:
        alu_result = op_a & op_b;
      isa_pkg::OP_OR:
        alu_result = op_a | op_b;
      isa_pkg::OP_XOR:
        alu_result = op_a ^ op_b;
      // Shift amount masked to the low bits of b
      isa_pkg::OP_SHL:
        alu_result = op_a << op_b[$clog2(reg_pkg::REG_WIDTH)-1:0];
      isa_pkg::OP_SHR:
        alu_result = op_a >> op_b[$clog2(reg_pkg::REG_WIDTH)-1:0];
      // Immediate is unsigned, upper bits fill with zero
      isa_pkg::OP_LDI:
        alu_result = reg_pkg::reg_word_t'(bus.imm);
      default:
        alu_result = '0;
    endcase
  end

  // Writeback valid
  // High for exactly one cycle per instruction
  always_ff @(posedge clk)
  begin
    if (rst)
      wb_en <= 1'b0;
    else
      wb_en <= bus.valid;
  end

  // Writeback payload
  // Feeds the register file write port and the top-level result
  always_ff @(posedge clk)
  begin
    if (bus.valid)
    begin
      wb_dst  <= bus.dst;
      wb_data <= alu_result;
    end
  end

endmodule

`default_nettype wire

// ==== source/operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

// Operand fetch stage
// Reads both sources from the register file in the issue cycle
// and lines up the instruction fields with the returned data
module operand_fetch (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue_valid,
  input  isa_pkg::opcode_t    issue_op,
  input  reg_pkg::reg_idx_t   issue_dst,
  input  reg_pkg::reg_idx_t   issue_src1,
  input  reg_pkg::reg_idx_t   issue_src2,
  input  isa_pkg::imm_t       issue_imm,
  input  logic                wb_en,
  input  reg_pkg::reg_idx_t   wb_dst,
  input  reg_pkg::reg_word_t  wb_data,
  operand_bus_if.fetch        bus
);

  // Register file
  // Reads only fire with an instruction, idle cycles leave the ports quiet
  // The write port takes the writeback register from execute
  // A read of the register being written returns the new value
  sram_2r1w #(
    .DATA_WIDTH (reg_pkg::REG_WIDTH),
    .SIZE       (reg_pkg::NUM_REGS)
  ) regfile_i (
    .clk        (clk),
    .read1_en   (issue_valid),
    .read1_adr  (issue_src1),
    .read1_data (bus.a),
    .read2_en   (issue_valid),
    .read2_adr  (issue_src2),
    .read2_data (bus.b),
    .write_en   (wb_en),
    .write_adr  (wb_dst),
    .write_data (wb_data)
  );

  // Strobe for the execute stage
  always_ff @(posedge clk)
  begin
    if (rst)
      bus.valid <= 1'b0;
    else
      bus.valid <= issue_valid;
  end

  // Instruction fields, same one-cycle delay as the SRAM read
  always_ff @(posedge clk)
  begin
    bus.op   <= issue_op;
    bus.dst  <= issue_dst;
    bus.src1 <= issue_src1;
    bus.src2 <= issue_src2;
    bus.imm  <= issue_imm;
  end

endmodule

`default_nettype wire

// ==== source/reg_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Two-stage integer execute pipeline
// Issue at edge t gives a result after edge t+1, register file
// write at edge t+2
module reg_exec_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue_valid,
  input  isa_pkg::opcode_t    issue_op,
  input  reg_pkg::reg_idx_t   issue_dst,
  input  reg_pkg::reg_idx_t   issue_src1,
  input  reg_pkg::reg_idx_t   issue_src2,
  input  isa_pkg::imm_t       issue_imm,
  output logic                result_valid,
  output reg_pkg::reg_idx_t   result_dst,
  output reg_pkg::reg_word_t  result_data
);

  // Writeback path, loops from execute back into the register file
  logic               wb_en;
  reg_pkg::reg_idx_t  wb_dst;
  reg_pkg::reg_word_t wb_data;

  // Fetch to execute
  operand_bus_if operand_bus ();

  operand_fetch fetch_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_dst   (issue_dst),
    .issue_src1  (issue_src1),
    .issue_src2  (issue_src2),
    .issue_imm   (issue_imm),
    .wb_en       (wb_en),
    .wb_dst      (wb_dst),
    .wb_data     (wb_data),
    .bus         (operand_bus.fetch)
  );

  execute_stage exec_i (
    .clk     (clk),
    .rst     (rst),
    .bus     (operand_bus.exec),
    .wb_en   (wb_en),
    .wb_dst  (wb_dst),
    .wb_data (wb_data)
  );

  // Result ports show the writeback register directly
  assign result_valid = wb_en;
  assign result_dst   = wb_dst;
  assign result_data  = wb_data;

endmodule

`default_nettype wire

// ==== source/sram_2r1w.sv ====
`timescale 1ns/1ps
`default_nettype none

// Two read ports, one write port, all synchronous on clk
// Read data shows up one cycle after the address and enable
module sram_2r1w #(
  parameter int DATA_WIDTH = 32,
  parameter int SIZE = 32,
  localparam int ADDR_WIDTH = $clog2(SIZE)
) (
  input  logic                  clk,
  input  logic                  read1_en,
  input  logic [ADDR_WIDTH-1:0] read1_adr,
  output logic [DATA_WIDTH-1:0] read1_data,
  input  logic                  read2_en,
  input  logic [ADDR_WIDTH-1:0] read2_adr,
  output logic [DATA_WIDTH-1:0] read2_data,
  input  logic                  write_en,
  input  logic [ADDR_WIDTH-1:0] write_adr,
  input  logic [DATA_WIDTH-1:0] write_data
);

  // Storage array, contents survive reset
  logic [DATA_WIDTH-1:0] data [SIZE];

  // Same-address hit on each read port this cycle
  logic hit1;
  logic hit2;

  assign hit1 = write_en && read1_en && (read1_adr == write_adr);
  assign hit2 = write_en && read2_en && (read2_adr == write_adr);

  always_ff @(posedge clk)
  begin
    if (write_en)
      data[write_adr] <= write_data;

    // Port 1
    // New data wins on a collision, otherwise the array word
    // A disabled port keeps its last output
    if (hit1)
      read1_data <= write_data;
    else if (read1_en)
      read1_data <= data[read1_adr];

    // Port 2, same rules as port 1
    if (hit2)
      read2_data <= write_data;
    else if (read2_en)
      read2_data <= data[read2_adr];
  end

endmodule

`default_nettype wire

// ==== tests/reg_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_exec_tb;

  // Stimulus sizes that also set the watchdog budget
  localparam int N_RAND  = 200;
  localparam int N_CHAIN = 60;
  localparam int N_GAP   = 60;
  localparam int MAX_GAP = 3;
  localparam int N_SAME  = 20;
  localparam int SETTLE  = 5;
  localparam int DRAIN   = 8;
  localparam int ISSUES  = reg_pkg::NUM_REGS + N_RAND + 2 * N_CHAIN + N_GAP + 3 * N_SAME;
  localparam int IDLES   = 3 + SETTLE + MAX_GAP * N_GAP + DRAIN;
  localparam int WATCHDOG_NS = (ISSUES + IDLES + 20) * 4;

  logic               clk;
  logic               rst;
  logic               issue_valid;
  isa_pkg::opcode_t   issue_op;
  reg_pkg::reg_idx_t  issue_dst;
  reg_pkg::reg_idx_t  issue_src1;
  reg_pkg::reg_idx_t  issue_src2;
  isa_pkg::imm_t      issue_imm;
  logic               result_valid;
  reg_pkg::reg_idx_t  result_dst;
  reg_pkg::reg_word_t result_data;

  // Architectural state as seen in program order
  reg_pkg::reg_word_t model_regs [reg_pkg::NUM_REGS];

  // Outstanding results with the oldest first
  reg_pkg::reg_idx_t  exp_dst_q [$];
  reg_pkg::reg_word_t exp_data_q [$];
  int unsigned        exp_due_q [$];

  // Rising edges seen so far
  int unsigned cycle = 0;

  // Popped entry under comparison
  reg_pkg::reg_idx_t  cmp_dst;
  reg_pkg::reg_word_t cmp_data;
  int unsigned        cmp_due;

  reg_exec_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_dst    (issue_dst),
    .issue_src1   (issue_src1),
    .issue_src2   (issue_src2),
    .issue_imm    (issue_imm),
    .result_valid (result_valid),
    .result_dst   (result_dst),
    .result_data  (result_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  // Expected ALU result with a as source 1 and b as source 2
  function automatic reg_pkg::reg_word_t alu_ref(input isa_pkg::opcode_t op,
                                                 input reg_pkg::reg_word_t a,
                                                 input reg_pkg::reg_word_t b,
                                                 input isa_pkg::imm_t imm);
    case (op)
      isa_pkg::OP_ADD: return a + b;
      isa_pkg::OP_SUB: return a - b;
      isa_pkg::OP_AND: return a & b;
      isa_pkg::OP_OR:  return a | b;
      isa_pkg::OP_XOR: return a ^ b;
      // Only five bits of shift amount count
      isa_pkg::OP_SHL: return a << b[4:0];
      isa_pkg::OP_SHR: return a >> b[4:0];
      default:         return {16'h0000, imm};
    endcase
  endfunction

  function automatic reg_pkg::reg_idx_t pick_reg();
    return reg_pkg::reg_idx_t'($urandom);
  endfunction

  function automatic isa_pkg::opcode_t pick_alu_op();
    return isa_pkg::opcode_t'($urandom_range(6, 0));
  endfunction

  task automatic check_dst(input reg_pkg::reg_idx_t got, input reg_pkg::reg_idx_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Fail result_dst got %h expected %h", got, exp));
  endtask

  task automatic check_data(input reg_pkg::reg_word_t got, input reg_pkg::reg_word_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Fail result_data got %h expected %h", got, exp));
  endtask

  // Model the instruction and queue its result
  // Then drive it for one cycle
  task automatic issue_instr(input isa_pkg::opcode_t op, input reg_pkg::reg_idx_t dst,
                             input reg_pkg::reg_idx_t s1, input reg_pkg::reg_idx_t s2,
                             input isa_pkg::imm_t imm);
    reg_pkg::reg_word_t exp;
    exp = alu_ref(op, model_regs[s1], model_regs[s2], imm);
    exp_dst_q.push_back(dst);
    exp_data_q.push_back(exp);
    exp_due_q.push_back(cycle + 2);
    model_regs[dst] = exp;
    issue_valid = 1'b1;
    issue_op    = op;
    issue_dst   = dst;
    issue_src1  = s1;
    issue_src2  = s2;
    issue_imm   = imm;
    @(posedge clk);
    #1;
  endtask

  // Idle cycles with junk on the fields
  // None of it may reach a result
  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      issue_valid = 1'b0;
      issue_op    = isa_pkg::opcode_t'($urandom);
      issue_dst   = pick_reg();
      issue_src1  = pick_reg();
      issue_src2  = pick_reg();
      issue_imm   = isa_pkg::imm_t'($urandom);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic load_all_regs();
    for (int r = 0; r < reg_pkg::NUM_REGS; r++)
      issue_instr(isa_pkg::OP_LDI, reg_pkg::reg_idx_t'(r), pick_reg(), pick_reg(),
                  isa_pkg::imm_t'($urandom));
  endtask

  // Every opcode back to back with independent random sources
  task automatic random_mix(input int n);
    repeat (n)
      issue_instr(isa_pkg::opcode_t'($urandom), pick_reg(), pick_reg(), pick_reg(),
                  isa_pkg::imm_t'($urandom));
  endtask

  // Each instruction reads the one just before it
  task automatic forward_chain(input int n);
    reg_pkg::reg_idx_t prev;
    reg_pkg::reg_idx_t dst;
    int mode;
    prev = pick_reg();
    issue_instr(pick_alu_op(), prev, pick_reg(), pick_reg(), '0);
    repeat (n - 1)
    begin
      dst  = pick_reg();
      mode = $urandom_range(2, 0);
      if (mode == 0)
        issue_instr(pick_alu_op(), dst, prev, pick_reg(), '0);
      else if (mode == 1)
        issue_instr(pick_alu_op(), dst, pick_reg(), prev, '0);
      else
        issue_instr(pick_alu_op(), dst, prev, prev, '0);
      prev = dst;
    end
  endtask

  // Source is the destination from two back
  // The middle instruction writes elsewhere
  task automatic bypass_chain(input int n);
    reg_pkg::reg_idx_t prev1;
    reg_pkg::reg_idx_t prev2;
    reg_pkg::reg_idx_t dst;
    reg_pkg::reg_idx_t other;
    prev2 = pick_reg();
    prev1 = reg_pkg::reg_idx_t'(prev2 + 1);
    repeat (n)
    begin
      do
        dst = pick_reg();
      while (dst == prev1);
      do
        other = pick_reg();
      while (other == prev1);
      if ($urandom_range(1, 0) == 0)
        issue_instr(pick_alu_op(), dst, prev2, other, '0);
      else
        issue_instr(pick_alu_op(), dst, other, prev2, '0);
      prev2 = prev1;
      prev1 = dst;
    end
  endtask

  task automatic gapped_issue(input int n);
    repeat (n)
    begin
      idle_cycles($urandom_range(MAX_GAP, 0));
      issue_instr(isa_pkg::opcode_t'($urandom), pick_reg(), pick_reg(), pick_reg(),
                  isa_pkg::imm_t'($urandom));
    end
  endtask

  // Both sources on one register
  // Read at distance 1 and then at distance 2
  task automatic same_source_ops(input int n);
    reg_pkg::reg_idx_t r;
    repeat (n)
    begin
      r = pick_reg();
      issue_instr(isa_pkg::OP_LDI, r, pick_reg(), pick_reg(), isa_pkg::imm_t'($urandom));
      issue_instr(isa_pkg::OP_XOR, pick_reg(), r, r, '0);
      issue_instr(pick_alu_op(), pick_reg(), r, r, '0);
    end
  endtask

  // Results checked against the queue in mid-cycle
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if ($isunknown(result_valid))
        stop_on_error("result_valid is unknown after reset");
      else if (result_valid)
      begin
        if (exp_dst_q.size() == 0)
          stop_on_error("result_valid went high with no instruction outstanding");
        else
        begin
          cmp_dst  = exp_dst_q.pop_front();
          cmp_data = exp_data_q.pop_front();
          cmp_due  = exp_due_q.pop_front();
          if (cycle != cmp_due)
            stop_on_error($sformatf("Result came at cycle %0d but was due at cycle %0d",
                                    cycle, cmp_due));
          else
          begin
            check_dst(result_dst, cmp_dst);
            check_data(result_data, cmp_data);
          end
        end
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    stop_on_error("Timeout, the run went past its time budget");
  end

  initial
  begin
    void'($urandom(32'hc230_f79e));
    rst         = 1'b1;
    issue_valid = 1'b0;
    issue_op    = '0;
    issue_dst   = '0;
    issue_src1  = '0;
    issue_src2  = '0;
    issue_imm   = '0;
    for (int r = 0; r < reg_pkg::NUM_REGS; r++)
      model_regs[r] = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    // Nothing issued yet and any result here is flagged
    idle_cycles(SETTLE);
    load_all_regs();
    random_mix(N_RAND);
    forward_chain(N_CHAIN);
    bypass_chain(N_CHAIN);
    gapped_issue(N_GAP);
    same_source_ops(N_SAME);
    idle_cycles(DRAIN);
    if (exp_dst_q.size() == 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
      stop_on_error($sformatf("%0d results never arrived", exp_dst_q.size()));
  end

endmodule

`default_nettype wire
